/* build.f */
verilog/cache_ctrl_pkg.sv
verilog/cache_meta_bits.sv
verilog/cache_way_select.sv
verilog/cache_fsm.sv
verilog/cache_wben_gen.sv
verilog/blocking_cache_ctrl.sv
verification/blocking_cache_ctrl_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the cache controller testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing --assert --timescale 1ns/1ns \
  -f build.f --top-module blocking_cache_ctrl_tb -o sim
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

./obj_dir/sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx "test passed" sim.log; then
  exit 0
fi
exit 1

/* verification/blocking_cache_ctrl_tb.sv */
//--------------------------------------------------------------------------
// Blocking cache controller testbench
// Directed tests against a tag/domain model and a delayed memory model
//--------------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module blocking_cache_ctrl_tb
  import cache_ctrl_pkg::*;
();

  localparam int timeout_cycles = 200;

  logic          clk = 1'b0;
  logic          reset = 1'b1;
  logic          cachereq_val = 1'b0;
  logic          cachereq_rdy;
  cache_req_t    cachereq = '0;
  logic          cacheresp_val;
  logic          cacheresp_rdy = 1'b1;
  req_type_e     cacheresp_type;
  logic          memreq_val;
  logic          memreq_rdy = 1'b1;
  mem_req_type_e memreq_type;
  domain_t       memreq_domain;
  logic          memresp_val = 1'b0;
  logic          memresp_rdy;
  domain_t       memresp_domain = 1'b0;
  dpath_status_t status;
  dpath_ctrl_t   ctrl;

  // Datapath model: tag and line domain per set and way
  logic [24:0]   tag_mem_0 [8];
  logic [24:0]   tag_mem_1 [8];
  domain_t       line_dom_0 [8];
  domain_t       line_dom_1 [8];
  domain_t       refill_dom;

  // Memory model
  logic [16:0]   lfsr_state = 17'd81538;
  domain_t       mem_domain = 1'b0;
  logic          mem_pending = 1'b0;
  logic [3:0]    mem_wait = '0;
  logic [3:0]    delay_bits;
  mem_req_type_e mem_log [$];

  // Per-request observations
  int            error_count = 0;
  int            timeout_count = 0;
  int            log_start;
  int            ren_count;
  int            wen_count;
  int            tag_wen_count;
  int            resp_cycle;
  dpath_ctrl_t   first_ren_ctrl;
  dpath_ctrl_t   first_wen_ctrl;

  always #2 clk = ~clk;

  blocking_cache_ctrl #(.num_sets(8)) u_dut (
    .clk, .reset, .cachereq_val, .cachereq_rdy, .cachereq, .cacheresp_val,
    .cacheresp_rdy, .cacheresp_type, .memreq_val, .memreq_rdy, .memreq_type,
    .memreq_domain, .memresp_val, .memresp_rdy, .memresp_domain, .status, .ctrl
  );

  //--------------------------------------------------------------------------
  // Datapath and memory models
  //--------------------------------------------------------------------------

  // Line in set index [6:4], tag [31:7]
  always_comb begin
    status.tag_match_0 = tag_mem_0[cachereq.addr[6:4]] == cachereq.addr[31:7];
    status.tag_match_1 = tag_mem_1[cachereq.addr[6:4]] == cachereq.addr[31:7];
    status.ns_match_0  = !(line_dom_0[cachereq.addr[6:4]] > cachereq.domain);
    status.ns_match_1  = !(line_dom_1[cachereq.addr[6:4]] > cachereq.domain);
  end

  always @(posedge clk) begin
    if (reset) begin
      for (int s = 0; s < 8; s++) begin
        tag_mem_0[s]  <= '0;
        tag_mem_1[s]  <= '0;
        line_dom_0[s] <= 1'b0;
        line_dom_1[s] <= 1'b0;
      end
      refill_dom <= 1'b0;
    end else begin
      if (memresp_val && memresp_rdy) refill_dom <= memresp_domain;
      if (ctrl.tag_array_0_wen) begin
        tag_mem_0[cachereq.addr[6:4]]  <= cachereq.addr[31:7];
        line_dom_0[cachereq.addr[6:4]] <= ctrl.is_refill ? refill_dom : cachereq.domain;
      end
      if (ctrl.tag_array_1_wen) begin
        tag_mem_1[cachereq.addr[6:4]]  <= cachereq.addr[31:7];
        line_dom_1[cachereq.addr[6:4]] <= ctrl.is_refill ? refill_dom : cachereq.domain;
      end
    end
  end

  function automatic logic [16:0] lfsr_next(input logic [16:0] s);
    return {s[15:0], s[16] ^ s[13]};
  endfunction

  // One LFSR step per bit taken
  task automatic take_random_bits(input int n, output logic [3:0] bits);
    bits = '0;
    for (int i = 0; i < n; i++) begin
      bits = {bits[2:0], lfsr_state[16]};
      lfsr_state = lfsr_next(lfsr_state);
    end
  endtask

  // Answers each memory request after 0 to 3 idle cycles
  always @(posedge clk) begin
    if (reset) begin
      memresp_val <= 1'b0;
      mem_pending <= 1'b0;
    end else begin
      if (memresp_val && memresp_rdy) memresp_val <= 1'b0;
      if (mem_pending) begin
        if (mem_wait == 0) begin
          memresp_val    <= 1'b1;
          memresp_domain <= mem_domain;
          mem_pending    <= 1'b0;
        end else begin
          mem_wait <= mem_wait - 1'b1;
        end
      end
      if (memreq_val && memreq_rdy) begin
        mem_log.push_back(memreq_type);
        take_random_bits(2, delay_bits);
        mem_pending <= 1'b1;
        mem_wait    <= delay_bits;
      end
    end
  end

  //--------------------------------------------------------------------------
  // Compare tasks and expected values
  //--------------------------------------------------------------------------

  task automatic report_failure(input string what);
    error_count++;
    $display("Failure at %0t ns: %s", $time, what);
  endtask

  task automatic report_timeout(input string what);
    timeout_count++;
    $display("Timeout at %0t ns: no %s within %0d cycles", $time, what, timeout_cycles);
  endtask

  task automatic check_req_type(input req_type_e got, input req_type_e exp, input string what);
    if (got !== exp) begin
      error_count++;
      $display("** Error at %0t ns: %s is %s, expected %s", $time, what, got.name(), exp.name());
    end
  endtask

  task automatic check_mem_type(input mem_req_type_e got, input mem_req_type_e exp,
                                input string what);
    if (got !== exp) begin
      error_count++;
      $display("** Error at %0t ns: %s is %s, expected %s", $time, what, got.name(), exp.name());
    end
  endtask

  task automatic check_ctrl(input dpath_ctrl_t got, input dpath_ctrl_t exp, input string what);
    if (got !== exp) begin
      error_count++;
      $display("** Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      error_count++;
      $display("** Error at %0t ns: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_count(input int got, input int exp, input string what);
    if (got != exp) begin
      error_count++;
      $display("** Error at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  // Memory requests seen since the request started, in order
  task automatic check_mem_log(input int n, input mem_req_type_e first,
                               input mem_req_type_e second);
    check_count(mem_log.size() - log_start, n, "memory request count");
    if (n >= 1 && mem_log.size() > log_start) begin
      check_mem_type(mem_log[log_start], first, "first memory request");
    end
    if (n >= 2 && mem_log.size() > log_start + 1) begin
      check_mem_type(mem_log[log_start + 1], second, "second memory request");
    end
  endtask

  function automatic logic [31:0] make_addr(input int tag, input int set, input int word);
    return (32'(tag) << 7) | (32'(set) << 4) | (32'(word) << 2);
  endfunction

  // Nothing active; wben decodes the word offset
  function automatic dpath_ctrl_t expected_ctrl(input logic [31:0] addr, input logic way);
    dpath_ctrl_t c;
    c = '0;
    c.way_sel         = way;
    c.read_word_sel   = addr[3:2];
    c.data_array_wben = 16'h000f << (4 * int'(addr[3:2]));
    return c;
  endfunction

  function automatic dpath_ctrl_t read_ctrl(input logic [31:0] addr, input logic way);
    dpath_ctrl_t c;
    c = expected_ctrl(addr, way);
    c.data_array_ren   = 1'b1;
    c.read_data_reg_en = 1'b1;
    return c;
  endfunction

  function automatic dpath_ctrl_t line_write_ctrl(input logic [31:0] addr, input logic way,
                                                  input logic refill);
    dpath_ctrl_t c;
    c = expected_ctrl(addr, way);
    c.tag_array_0_wen = !way;
    c.tag_array_1_wen = way;
    c.data_array_wen  = 1'b1;
    c.is_refill       = refill;
    if (refill) c.data_array_wben = '1;
    return c;
  endfunction

  //--------------------------------------------------------------------------
  // Request driver and monitor
  //--------------------------------------------------------------------------

  task automatic issue_request(input req_type_e req_type, input logic [31:0] addr,
                               input domain_t domain, input int memreq_stall,
                               input int resp_stall);
    logic          accepted;
    logic          done;
    int            mem_held;
    int            resp_held;
    mem_req_type_e held_type;
    dpath_ctrl_t   c;
    log_start     = mem_log.size();
    ren_count     = 0;
    wen_count     = 0;
    tag_wen_count = 0;
    resp_cycle    = 0;
    mem_held      = 0;
    resp_held     = 0;
    held_type     = MEM_READ;
    accepted      = 1'b0;
    done          = 1'b0;
    cachereq_val <= 1'b1;
    cachereq     <= '{req_type: req_type, addr: addr, domain: domain};
    if (memreq_stall > 0) memreq_rdy <= 1'b0;
    if (resp_stall > 0) cacheresp_rdy <= 1'b0;
    for (int i = 0; i < timeout_cycles && !accepted; i++) begin
      @(posedge clk);
      accepted = cachereq_val && cachereq_rdy;
    end
    cachereq_val <= 1'b0;
    // Edge counts below are relative to the accepting edge
    for (int i = 1; i <= timeout_cycles && accepted && !done; i++) begin
      @(posedge clk);
      c = ctrl;
      if (c.data_array_ren) begin
        ren_count++;
        if (ren_count == 1) first_ren_ctrl = c;
      end
      if (c.data_array_wen) begin
        wen_count++;
        if (wen_count == 1) first_wen_ctrl = c;
      end
      if (c.tag_array_0_wen || c.tag_array_1_wen) tag_wen_count++;
      // Memory requests carry the requester domain
      if (memreq_val) check_flag(memreq_domain, domain, "memreq_domain");
      if (cacheresp_val) check_flag(memresp_rdy, 1'b0, "memresp_rdy while responding");
      if (cacheresp_val && resp_cycle == 0) resp_cycle = i;
      if (memreq_stall > 0 && !memreq_rdy) begin
        if (memreq_val) begin
          if (mem_held == 0) held_type = memreq_type;
          else check_mem_type(memreq_type, held_type, "memreq_type while stalled");
          mem_held++;
          if (mem_held == memreq_stall) memreq_rdy <= 1'b1;
        end else if (mem_held > 0) begin
          report_failure("memreq_val dropped while memreq_rdy was low");
        end
      end
      if (resp_stall > 0 && !cacheresp_rdy) begin
        if (cacheresp_val) begin
          if (cachereq_rdy) report_failure("cachereq_rdy high while the response was stalled");
          resp_held++;
          if (resp_held == resp_stall) cacheresp_rdy <= 1'b1;
        end else if (resp_held > 0) begin
          report_failure("cacheresp_val dropped while cacheresp_rdy was low");
        end
      end
      done = cacheresp_val && cacheresp_rdy;
    end
    memreq_rdy    <= 1'b1;
    cacheresp_rdy <= 1'b1;
    if (!accepted) report_timeout("request acceptance");
    else if (!done) report_timeout("cache response");
    else check_req_type(cacheresp_type, req_type, "cacheresp_type");
  endtask

  //--------------------------------------------------------------------------
  // Directed tests
  //--------------------------------------------------------------------------

  task automatic test_reset_cold_miss();
    dpath_ctrl_t exp;
    logic [31:0] addr;
    exp = expected_ctrl(32'h0, 1'b0);
    exp.cachereq_en = 1'b1;
    addr = make_addr(1, 0, 1);
    check_flag(cachereq_rdy, 1'b1, "cachereq_rdy after reset");
    check_flag(memreq_val, 1'b0, "memreq_val after reset");
    check_flag(cacheresp_val, 1'b0, "cacheresp_val after reset");
    check_flag(memresp_rdy, 1'b0, "memresp_rdy after reset");
    check_ctrl(ctrl, exp, "ctrl in idle");
    issue_request(REQ_READ, addr, 1'b0, 0, 0);
    check_mem_log(1, MEM_READ, MEM_READ);
    check_count(wen_count, 1, "data array writes on cold miss");
    check_ctrl(first_wen_ctrl, line_write_ctrl(addr, 1'b0, 1'b1), "refill write");
  endtask

  task automatic test_read_hit();
    logic [31:0] addr;
    addr = make_addr(1, 0, 1);
    issue_request(REQ_READ, addr, 1'b0, 0, 0);
    check_mem_log(0, MEM_READ, MEM_READ);
    check_count(resp_cycle, 3, "read hit response edge");
    check_count(ren_count, 1, "data array reads on hit");
    check_ctrl(first_ren_ctrl, read_ctrl(addr, 1'b0), "read access");
  endtask

  task automatic test_write_lru_evict();
    logic [31:0] addr;
    addr = make_addr(1, 0, 2);
    issue_request(REQ_WRITE, addr, 1'b0, 0, 0);
    check_mem_log(0, MEM_READ, MEM_READ);
    check_count(resp_cycle, 3, "write hit response edge");
    check_ctrl(first_wen_ctrl, line_write_ctrl(addr, 1'b0, 1'b0), "write hit");
    // Way 1 is now least recently used and clean
    addr = make_addr(2, 0, 0);
    issue_request(REQ_READ, addr, 1'b0, 0, 0);
    check_mem_log(1, MEM_READ, MEM_READ);
    check_ctrl(first_wen_ctrl, line_write_ctrl(addr, 1'b1, 1'b1), "refill into way 1");
    // Dirty way 0 goes back to memory first
    addr = make_addr(3, 0, 3);
    issue_request(REQ_READ, addr, 1'b0, 0, 0);
    check_mem_log(2, MEM_WRITE, MEM_READ);
    check_ctrl(first_wen_ctrl, line_write_ctrl(addr, 1'b0, 1'b1), "refill after eviction");
  endtask

  task automatic test_fake_hits();
    logic [31:0] addr;
    addr = make_addr(5, 1, 0);
    mem_domain <= 1'b1;
    issue_request(REQ_READ, addr, 1'b0, 0, 0);
    check_mem_log(1, MEM_READ, MEM_READ);
    check_count(ren_count, 0, "data array reads on fake read");
    issue_request(REQ_WRITE, addr, 1'b0, 0, 0);
    check_mem_log(0, MEM_READ, MEM_READ);
    check_count(resp_cycle, 3, "fake write response edge");
    check_count(wen_count, 0, "data array writes on fake write");
    check_count(tag_wen_count, 0, "tag writes on fake write");
    check_count(ren_count, 0, "data array reads on fake write");
    issue_request(REQ_READ, addr, 1'b1, 0, 0);
    check_mem_log(0, MEM_READ, MEM_READ);
    check_count(resp_cycle, 3, "privileged read response edge");
    check_ctrl(first_ren_ctrl, read_ctrl(addr, 1'b0), "privileged read hit");
    mem_domain <= 1'b0;
  endtask

  task automatic test_init_backpressure();
    logic [31:0] addr;
    addr = make_addr(7, 2, 1);
    issue_request(REQ_WRITE_INIT, addr, 1'b0, 0, 0);
    check_mem_log(0, MEM_READ, MEM_READ);
    check_count(resp_cycle, 3, "init response edge");
    check_count(wen_count, 1, "data array writes on init");
    check_ctrl(first_wen_ctrl, line_write_ctrl(addr, 1'b0, 1'b0), "init write");
    addr = make_addr(8, 2, 0);
    issue_request(REQ_READ, addr, 1'b0, 3, 0);
    check_mem_log(1, MEM_READ, MEM_READ);
    check_ctrl(first_wen_ctrl, line_write_ctrl(addr, 1'b1, 1'b1), "refill into way 1");
    // Victim is the clean init line, so no write-back
    addr = make_addr(9, 2, 2);
    issue_request(REQ_READ, addr, 1'b0, 0, 4);
    check_mem_log(1, MEM_READ, MEM_READ);
    check_ctrl(first_wen_ctrl, line_write_ctrl(addr, 1'b0, 1'b1), "refill over init line");
  endtask

  initial begin
    repeat (10) @(posedge clk);
    reset <= 1'b0;
    @(posedge clk);
    test_reset_cold_miss();
    test_read_hit();
    test_write_lru_evict();
    test_fake_hits();
    test_init_backpressure();
    $display("Done: %0d errors, %0d timeouts", error_count, timeout_count);
    if (error_count == 0 && timeout_count == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verilog/blocking_cache_ctrl.sv */
//--------------------------------------------------------------------------
// Blocking cache controller
// Two-way write-back cache control with security-domain fake hits
//--------------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module blocking_cache_ctrl
  import cache_ctrl_pkg::*;
#(
  parameter int num_sets  = 8,
  parameter int idx_shift = 0
) (
  input  logic          clk,
  input  logic          reset,
  // Processor side
  input  logic          cachereq_val,
  output logic          cachereq_rdy,
  input  cache_req_t    cachereq,
  output logic          cacheresp_val,
  input  logic          cacheresp_rdy,
  output req_type_e     cacheresp_type,
  // Memory side
  output logic          memreq_val,
  input  logic          memreq_rdy,
  output mem_req_type_e memreq_type,
  output domain_t       memreq_domain,
  input  logic          memresp_val,
  output logic          memresp_rdy,
  input  domain_t       memresp_domain,
  // Datapath
  input  dpath_status_t status,
  output dpath_ctrl_t   ctrl
);

  localparam int idx_bits     = $clog2(num_sets);
  localparam int line_off     = $clog2(LINE_BYTES);
  localparam int word_off     = $clog2(WORD_BITS / 8);

  logic [idx_bits-1:0]      index;
  logic [WORD_SEL_BITS-1:0] word_offset;

  logic hit, fake_hit, refill, evict, way_sel;
  logic valid_0, valid_1, dirty_0, dirty_1, lru_way;
  logic record_en, valid_wen, valid_in, dirty_wen, dirty_in, lru_wen;
  logic is_refill, cachereq_en, memresp_en, tag_wen, tag_array_ren;
  logic data_array_wen, data_array_ren, read_data_reg_en, read_tag_reg_en;
  logic [LINE_BYTES-1:0]    data_array_wben;
  logic [WORD_SEL_BITS-1:0] read_word_sel;

  assign index       = cachereq.addr[line_off + idx_shift +: idx_bits];
  assign word_offset = cachereq.addr[word_off +: WORD_SEL_BITS];

  assign cacheresp_type = cachereq.req_type;
  assign memreq_domain  = cachereq.domain;

  cache_fsm u_fsm (
    .clk, .reset, .cachereq_val, .cachereq, .cacheresp_rdy, .memreq_rdy,
    .memresp_val, .memresp_domain, .hit, .fake_hit, .refill, .evict,
    .cachereq_rdy, .cacheresp_val, .memreq_val, .memreq_type, .memresp_rdy,
    .record_en, .valid_wen, .valid_in, .dirty_wen, .dirty_in, .lru_wen,
    .is_refill, .cachereq_en, .memresp_en, .tag_wen, .tag_array_ren,
    .data_array_wen, .data_array_ren, .read_data_reg_en, .read_tag_reg_en
  );

  cache_meta_bits #(.num_sets(num_sets)) u_meta (
    .clk, .reset, .index, .way_sel, .valid_wen, .valid_in, .dirty_wen,
    .dirty_in, .lru_wen, .valid_0, .valid_1, .dirty_0, .dirty_1, .lru_way
  );

  cache_way_select u_way_sel (
    .clk, .reset, .record_en, .status, .valid_0, .valid_1, .dirty_0,
    .dirty_1, .lru_way, .hit, .fake_hit, .refill, .evict, .way_sel
  );

  cache_wben_gen u_wben (
    .word_offset, .is_refill, .data_array_wben, .read_word_sel
  );

  // Datapath control packing
  always_comb begin
    ctrl.cachereq_en      = cachereq_en;
    ctrl.memresp_en       = memresp_en;
    ctrl.is_refill        = is_refill;
    ctrl.tag_array_0_wen  = tag_wen && !way_sel;
    ctrl.tag_array_1_wen  = tag_wen && way_sel;
    ctrl.tag_array_ren    = tag_array_ren;
    ctrl.way_sel          = way_sel;
    ctrl.data_array_wen   = data_array_wen;
    ctrl.data_array_ren   = data_array_ren;
    ctrl.data_array_wben  = data_array_wben;
    ctrl.read_data_reg_en = read_data_reg_en;
    ctrl.read_tag_reg_en  = read_tag_reg_en;
    ctrl.read_word_sel    = read_word_sel;
  end

endmodule

`default_nettype wire

/* verilog/cache_wben_gen.sv */
//--------------------------------------------------------------------------
// Data array byte write enables and read word select
//--------------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module cache_wben_gen
  import cache_ctrl_pkg::*;
(
  input  logic [WORD_SEL_BITS-1:0] word_offset,
  input  logic                     is_refill,
  output logic [LINE_BYTES-1:0]    data_array_wben,
  output logic [WORD_SEL_BITS-1:0] read_word_sel
);

  localparam int word_bytes = WORD_BITS / 8;

  always_comb begin
    data_array_wben = '0;
    if (is_refill) begin
      // Refill writes the whole line
      data_array_wben = '1;
    end else begin
      for (int b = 0; b < LINE_BYTES; b++) begin
        data_array_wben[b] = (b / word_bytes) == int'(word_offset);
      end
    end
  end

  assign read_word_sel = word_offset;

endmodule

`default_nettype wire

/* verilog/cache_fsm.sv */
//--------------------------------------------------------------------------
// Blocking cache FSM
// Request/response sequencing, refill and eviction, fake accesses
//--------------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module cache_fsm
  import cache_ctrl_pkg::*;
(
  input  logic          clk,
  input  logic          reset,
  input  logic          cachereq_val,
  input  cache_req_t    cachereq,
  input  logic          cacheresp_rdy,
  input  logic          memreq_rdy,
  input  logic          memresp_val,
  input  domain_t       memresp_domain,
  input  logic          hit,
  input  logic          fake_hit,
  input  logic          refill,
  input  logic          evict,
  output logic          cachereq_rdy,
  output logic          cacheresp_val,
  output logic          memreq_val,
  output mem_req_type_e memreq_type,
  output logic          memresp_rdy,
  output logic          record_en,
  output logic          valid_wen,
  output logic          valid_in,
  output logic          dirty_wen,
  output logic          dirty_in,
  output logic          lru_wen,
  output logic          is_refill,
  output logic          cachereq_en,
  output logic          memresp_en,
  output logic          tag_wen,
  output logic          tag_array_ren,
  output logic          data_array_wen,
  output logic          data_array_ren,
  output logic          read_data_reg_en,
  output logic          read_tag_reg_en
);

  cache_state_e state_q;
  cache_state_e state_next;
  domain_t      line_domain_q;

  logic in_go;
  logic out_go;
  logic is_read;
  logic is_write;
  logic is_init;
  logic line_more_priv;

  assign in_go    = cachereq_val && cachereq_rdy;
  assign out_go   = cacheresp_val && cacheresp_rdy;
  assign is_read  = cachereq.req_type == REQ_READ;
  assign is_write = cachereq.req_type == REQ_WRITE;
  assign is_init  = cachereq.req_type == REQ_WRITE_INIT;

  // Domain of the refilled line, taken on the response transfer
  always_ff @(posedge clk) begin
    if (state_q == ST_REFILL_WAIT && memresp_val) begin
      line_domain_q <= memresp_domain;
    end
  end

  assign line_more_priv = line_domain_q > cachereq.domain;

  always_ff @(posedge clk) begin
    if (reset) begin
      state_q <= ST_IDLE;
    end else begin
      state_q <= state_next;
    end
  end

  //--------------------------------------------------------------------------
  // Next state
  //--------------------------------------------------------------------------

  always_comb begin
    state_next = state_q;
    case (state_q)
      ST_IDLE:          if (in_go) state_next = ST_TAG_CHECK;
      ST_TAG_CHECK: begin
        if (is_init)                    state_next = ST_INIT_ACCESS;
        else if (is_read && hit)        state_next = ST_READ_ACCESS;
        else if (is_read && fake_hit)   state_next = ST_FAKE_READ;
        else if (is_write && hit)       state_next = ST_WRITE_ACCESS;
        else if (is_write && fake_hit)  state_next = ST_FAKE_WRITE;
        else if (refill)                state_next = ST_REFILL_REQ;
        else if (evict)                 state_next = ST_EVICT_PREPARE;
      end
      ST_READ_ACCESS, ST_FAKE_READ, ST_WRITE_ACCESS, ST_FAKE_WRITE,
      ST_INIT_ACCESS:   state_next = ST_WAIT;
      ST_REFILL_REQ:    if (memreq_rdy) state_next = ST_REFILL_WAIT;
      ST_REFILL_WAIT:   if (memresp_val) state_next = ST_REFILL_UPDATE;
      ST_REFILL_UPDATE: begin
        // Line from a more privileged domain is answered without data
        if (is_write) state_next = line_more_priv ? ST_FAKE_WRITE : ST_WRITE_ACCESS;
        else          state_next = line_more_priv ? ST_FAKE_READ : ST_READ_ACCESS;
      end
      ST_EVICT_PREPARE: state_next = ST_EVICT_REQ;
      ST_EVICT_REQ:     if (memreq_rdy) state_next = ST_EVICT_WAIT;
      ST_EVICT_WAIT:    if (memresp_val) state_next = ST_REFILL_REQ;
      ST_WAIT:          if (out_go) state_next = ST_IDLE;
      default:          state_next = ST_IDLE;
    endcase
  end

  //--------------------------------------------------------------------------
  // Output decode
  //--------------------------------------------------------------------------

  always_comb begin
    cachereq_rdy     = 1'b0;
    cacheresp_val    = 1'b0;
    memreq_val       = 1'b0;
    memreq_type      = MEM_READ;
    memresp_rdy      = 1'b0;
    record_en        = 1'b0;
    valid_wen        = 1'b0;
    valid_in         = 1'b0;
    dirty_wen        = 1'b0;
    dirty_in         = 1'b0;
    lru_wen          = 1'b0;
    is_refill        = 1'b0;
    cachereq_en      = 1'b0;
    memresp_en       = 1'b0;
    tag_wen          = 1'b0;
    tag_array_ren    = 1'b0;
    data_array_wen   = 1'b0;
    data_array_ren   = 1'b0;
    read_data_reg_en = 1'b0;
    read_tag_reg_en  = 1'b0;
    case (state_q)
      ST_IDLE: begin
        cachereq_rdy = 1'b1;
        cachereq_en  = 1'b1;
      end
      ST_TAG_CHECK: begin
        tag_array_ren = 1'b1;
        record_en     = 1'b1;
      end
      ST_READ_ACCESS: begin
        data_array_ren   = 1'b1;
        read_data_reg_en = 1'b1;
        lru_wen          = 1'b1;
      end
      ST_FAKE_READ:     read_data_reg_en = 1'b1;
      ST_WRITE_ACCESS, ST_INIT_ACCESS: begin
        tag_wen        = 1'b1;
        data_array_wen = 1'b1;
        valid_wen      = 1'b1;
        valid_in       = 1'b1;
        dirty_wen      = 1'b1;
        // Init leaves the line clean
        dirty_in       = (state_q == ST_WRITE_ACCESS);
        lru_wen        = 1'b1;
      end
      ST_REFILL_REQ: begin
        memreq_val  = 1'b1;
        memreq_type = MEM_READ;
      end
      ST_REFILL_WAIT: begin
        memresp_rdy = 1'b1;
        memresp_en  = 1'b1;
      end
      ST_REFILL_UPDATE: begin
        is_refill      = 1'b1;
        tag_wen        = 1'b1;
        data_array_wen = 1'b1;
        valid_wen      = 1'b1;
        valid_in       = 1'b1;
        dirty_wen      = 1'b1;
      end
      ST_EVICT_PREPARE: begin
        tag_array_ren    = 1'b1;
        data_array_ren   = 1'b1;
        read_data_reg_en = 1'b1;
        read_tag_reg_en  = 1'b1;
      end
      ST_EVICT_REQ: begin
        memreq_val  = 1'b1;
        memreq_type = MEM_WRITE;
      end
      ST_EVICT_WAIT:    memresp_rdy = 1'b1;
      ST_WAIT:          cacheresp_val = 1'b1;
      default: ;
    endcase
  end

  // Handshake inputs from both sides must be known after reset
  a_inputs_known: assert property (@(posedge clk) disable iff (reset)
    !$isunknown({cachereq_val, cacheresp_rdy, memreq_rdy, memresp_val}))
    else $error("handshake input is X");

endmodule

`default_nettype wire

/* verilog/cache_way_select.sv */
//--------------------------------------------------------------------------
// Way selection
// Hit, fake-hit, refill and evict decisions plus the per-transaction way
//--------------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module cache_way_select
  import cache_ctrl_pkg::*;
(
  input  logic          clk,
  input  logic          reset,
  input  logic          record_en,
  input  dpath_status_t status,
  input  logic          valid_0,
  input  logic          valid_1,
  input  logic          dirty_0,
  input  logic          dirty_1,
  input  logic          lru_way,
  output logic          hit,
  output logic          fake_hit,
  output logic          refill,
  output logic          evict,
  output logic          way_sel
);

  logic hit_0;
  logic hit_1;
  logic fake_hit_0;
  logic fake_hit_1;
  logic miss;
  logic victim_dirty;
  logic way_next;

  // Tag match in a valid way, split on the domain check
  assign hit_0      = valid_0 && status.tag_match_0 && status.ns_match_0;
  assign hit_1      = valid_1 && status.tag_match_1 && status.ns_match_1;
  assign fake_hit_0 = valid_0 && status.tag_match_0 && !status.ns_match_0;
  assign fake_hit_1 = valid_1 && status.tag_match_1 && !status.ns_match_1;

  assign hit      = hit_0 || hit_1;
  assign fake_hit = fake_hit_0 || fake_hit_1;
  assign miss     = !hit && !fake_hit;

  // Victim is always the LRU way
  assign victim_dirty = lru_way ? dirty_1 : dirty_0;
  assign refill       = miss && !victim_dirty;
  assign evict        = miss && victim_dirty;

  assign way_next = hit ? hit_1 : lru_way;

  always_ff @(posedge clk) begin
    if (reset) begin
      way_sel <= 1'b0;
    end else if (record_en) begin
      way_sel <= way_next;
    end
  end

  // Tag arrays must never hold the same tag twice in one set
  a_single_hit: assert property (@(posedge clk) disable iff (reset)
    record_en |-> !(hit_0 && hit_1))
    else $error("both ways hit in the same set");

endmodule

`default_nettype wire

/* verilog/cache_meta_bits.sv */
//--------------------------------------------------------------------------
// Cache metadata bits
// Valid and dirty bits per way, one LRU bit per set
//--------------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module cache_meta_bits #(
  parameter int num_sets = 8,
  localparam int idx_bits = $clog2(num_sets)
) (
  input  logic                clk,
  input  logic                reset,
  input  logic [idx_bits-1:0] index,
  input  logic                way_sel,
  input  logic                valid_wen,
  input  logic                valid_in,
  input  logic                dirty_wen,
  input  logic                dirty_in,
  input  logic                lru_wen,
  output logic                valid_0,
  output logic                valid_1,
  output logic                dirty_0,
  output logic                dirty_1,
  output logic                lru_way
);

  logic [num_sets-1:0] valid_0_bits;
  logic [num_sets-1:0] valid_1_bits;
  logic [num_sets-1:0] dirty_0_bits;
  logic [num_sets-1:0] dirty_1_bits;
  logic [num_sets-1:0] lru_bits;

  always_ff @(posedge clk) begin
    if (reset) begin
      valid_0_bits <= '0;
      valid_1_bits <= '0;
      dirty_0_bits <= '0;
      dirty_1_bits <= '0;
      lru_bits     <= '0;
    end else begin
      if (valid_wen && !way_sel) valid_0_bits[index] <= valid_in;
      if (valid_wen && way_sel)  valid_1_bits[index] <= valid_in;
      if (dirty_wen && !way_sel) dirty_0_bits[index] <= dirty_in;
      if (dirty_wen && way_sel)  dirty_1_bits[index] <= dirty_in;
      // The way just used becomes most recent
      if (lru_wen)               lru_bits[index]     <= ~way_sel;
    end
  end

  assign valid_0 = valid_0_bits[index];
  assign valid_1 = valid_1_bits[index];
  assign dirty_0 = dirty_0_bits[index];
  assign dirty_1 = dirty_1_bits[index];
  assign lru_way = lru_bits[index];

  // Strobes from the FSM must be known once out of reset
  a_strobes_known: assert property (@(posedge clk) disable iff (reset)
    !$isunknown({valid_wen, dirty_wen, lru_wen}))
    else $error("metadata write strobe is X");

endmodule

`default_nettype wire

/* verilog/cache_ctrl_pkg.sv */
//--------------------------------------------------------------------------
// Cache controller package
// Geometry, opcodes, FSM states and the datapath control/status structs
//--------------------------------------------------------------------------
`default_nettype none

package cache_ctrl_pkg;

  // Geometry
  localparam int WORD_BITS     = 32;
  localparam int LINE_BITS     = 128;
  localparam int LINE_BYTES    = LINE_BITS / 8;
  localparam int WORD_SEL_BITS = 2;
  localparam int ADDR_BITS     = 32;

  // Security domain, 1 is the more privileged one
  typedef logic domain_t;

  typedef enum logic [2:0] {
    REQ_READ       = 3'd0,
    REQ_WRITE      = 3'd1,
    REQ_WRITE_INIT = 3'd2
  } req_type_e;

  typedef enum logic {
    MEM_READ  = 1'b0,
    MEM_WRITE = 1'b1
  } mem_req_type_e;

  typedef enum logic [3:0] {
    ST_IDLE,
    ST_TAG_CHECK,
    ST_READ_ACCESS,
    ST_FAKE_READ,
    ST_WRITE_ACCESS,
    ST_FAKE_WRITE,
    ST_INIT_ACCESS,
    ST_REFILL_REQ,
    ST_REFILL_WAIT,
    ST_REFILL_UPDATE,
    ST_EVICT_PREPARE,
    ST_EVICT_REQ,
    ST_EVICT_WAIT,
    ST_WAIT
  } cache_state_e;

  // Held request, as captured by the datapath
  typedef struct packed {
    req_type_e              req_type;
    logic [ADDR_BITS-1:0]   addr;
    domain_t                domain;
  } cache_req_t;

  typedef struct packed {
    logic tag_match_0;
    logic tag_match_1;
    logic ns_match_0;
    logic ns_match_1;
  } dpath_status_t;

  typedef struct packed {
    logic                     cachereq_en;
    logic                     memresp_en;
    logic                     is_refill;
    logic                     tag_array_0_wen;
    logic                     tag_array_1_wen;
    logic                     tag_array_ren;
    logic                     way_sel;
    logic                     data_array_wen;
    logic                     data_array_ren;
    logic [LINE_BYTES-1:0]    data_array_wben;
    logic                     read_data_reg_en;
    logic                     read_tag_reg_en;
    logic [WORD_SEL_BITS-1:0] read_word_sel;
  } dpath_ctrl_t;

endpackage

`default_nettype wire
